/* dpe_pkg.sv */
// --------------------
// Data-plane engine shared types
// Stream beat fields, sideband layout and register map
// --------------------
`default_nettype none

package dpe_pkg;

    typedef logic [127:0] tdata_t;
    typedef logic [15:0]  tkeep_t;
    typedef logic [4:0]   in_user_t;
    typedef logic [127:0] out_user_t;
    typedef logic [31:0]  rcv_idx_t;
    typedef logic [63:0]  wg_ctr_t;
    typedef logic [47:0]  enp_t;
    typedef logic [1:0]   reg_addr_t;
    typedef logic [31:0]  reg_data_t;

    // Register map
    localparam reg_addr_t REG_CTRL    = 2'd0;
    localparam reg_addr_t REG_WG_CNT  = 2'd1;
    localparam reg_addr_t REG_BYP_CNT = 2'd2;
    localparam int        CTRL_DECAP_EN_BIT = 0;

    // Egress sideband layout
    // Bits outside these fields stay zero
    localparam int OUSER_RCV_LSB   = 96;
    localparam int OUSER_CTR_LSB   = 32;
    localparam int OUSER_DECAP_BIT = 5;
    localparam int OUSER_IN_LSB    = 0;

endpackage

`default_nettype wire

/* wg_proto_pkg.sv */
// --------------------
// Protocol constants and field positions
// Ethernet/IPv4/UDP/WireGuard header as seen on 128-bit beats
// --------------------
`default_nettype none

package wg_proto_pkg;

    // Beat 0
    localparam logic [15:0] ETHERTYPE_IP_LANES = 16'h0008;
    localparam int          ETH_TYPE_LSB       = 96;
    localparam logic [3:0]  IPV4_VERSION       = 4'd4;
    localparam int          IP_VER_LSB         = 116;

    // Beat 1
    localparam logic [7:0]  IPPROTO_UDP  = 8'h11;
    localparam int          IP_PROTO_LSB = 56;

    // Beats 2 and 3
    localparam logic [7:0]  WG_MSG_DATA   = 8'd4;
    localparam int          WG_TYPE_LSB   = 80;
    localparam int          WG_RCV_LO_LSB = 112;
    localparam int          WG_RCV_HI_LSB = 0;
    localparam int          WG_CTR_LSB    = 16;
    localparam int          PAYLOAD_LSB   = 80;

    // Header beats seen ahead of the data
    localparam int HDR_BEATS = 3;

endpackage

`default_nettype wire

/* pkt_if.sv */
// --------------------
// Stream interface and the datapath/register control link
// --------------------
`default_nettype none

interface pkt_if #(
    parameter int USER_W = 5
);
    import dpe_pkg::*;

    logic              tvalid;
    logic              tready;
    tdata_t            tdata;
    tkeep_t            tkeep;
    logic              tlast;
    logic [USER_W-1:0] tuser;

    modport src (output tvalid, tdata, tkeep, tlast, tuser, input tready);
    modport snk (input tvalid, tdata, tkeep, tlast, tuser, output tready);
endinterface

// Enable from the registers, frame events and idle from the datapath
interface wg_ctl_if;
    logic decap_en;
    logic wg_done;
    logic byp_done;
    logic idle;

    modport dp   (input decap_en, output wg_done, byp_done, idle);
    modport regs (output decap_en, input wg_done, byp_done, idle);
endinterface

`default_nettype wire

/* pkt_pipe.sv */
// --------------------
// Three-stage stream pipeline
// Gives the classifier look-ahead over the header beats
// --------------------
`default_nettype none

module pkt_pipe #(
    parameter int USER_W = 5
) (
    input  logic clk,
    input  logic rst,
    pkt_if.snk   s,
    pkt_if.src   m
);
    import dpe_pkg::*;

    localparam int DEPTH = 3;

    typedef struct packed {
        tdata_t            data;
        tkeep_t            keep;
        logic              last;
        logic [USER_W-1:0] user;
    } beat_t;

    beat_t            st [DEPTH];
    logic [DEPTH-1:0] vld;
    logic [DEPTH:0]   rdy;

    // A stage takes a beat when empty or when the stage after it moves on
    always_comb begin
        rdy[DEPTH] = m.tready;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            rdy[i] = !vld[i] || rdy[i+1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            if (rdy[0]) begin
                vld[0] <= s.tvalid;
            end
            for (int i = 1; i < DEPTH; i++) begin
                if (rdy[i]) begin
                    vld[i] <= vld[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy[0] && s.tvalid) begin
            st[0] <= '{data: s.tdata, keep: s.tkeep, last: s.tlast, user: s.tuser};
        end
        for (int i = 1; i < DEPTH; i++) begin
            if (rdy[i] && vld[i-1]) begin
                st[i] <= st[i-1];
            end
        end
    end

    assign s.tready = rdy[0];
    assign m.tvalid = vld[DEPTH-1];
    assign m.tdata  = st[DEPTH-1].data;
    assign m.tkeep  = st[DEPTH-1].keep;
    assign m.tlast  = st[DEPTH-1].last;
    assign m.tuser  = st[DEPTH-1].user;

    // Stalled output beat must hold until taken
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        m.tvalid && !m.tready |=> m.tvalid && $stable(st[DEPTH-1]));

endmodule

`default_nettype wire

/* pkt_skid.sv */
// --------------------
// Two-entry skid buffer
// Registered input ready, one cycle latency
// --------------------
`default_nettype none

module pkt_skid #(
    parameter int USER_W = 128
) (
    input  logic clk,
    input  logic rst,
    pkt_if.snk   s,
    pkt_if.src   m
);
    import dpe_pkg::*;

    typedef struct packed {
        tdata_t            data;
        tkeep_t            keep;
        logic              last;
        logic [USER_W-1:0] user;
    } beat_t;

    beat_t main_q;
    beat_t spare_q;
    beat_t in_beat;
    logic  main_v;
    logic  spare_v;
    logic  s_xfer;
    logic  main_free;

    assign in_beat   = '{data: s.tdata, keep: s.tkeep, last: s.tlast, user: s.tuser};
    assign s_xfer    = s.tvalid && s.tready;
    assign main_free = !main_v || m.tready;

    // Spare slot only fills while the output is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            main_v  <= 1'b0;
            spare_v <= 1'b0;
        end else if (s_xfer) begin
            if (main_free) begin
                main_v <= 1'b1;
            end else begin
                spare_v <= 1'b1;
            end
        end else if (main_free) begin
            main_v  <= spare_v;
            spare_v <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s_xfer && main_free) begin
            main_q <= in_beat;
        end else if (main_free && spare_v) begin
            main_q <= spare_q;
        end
        if (s_xfer && !main_free) begin
            spare_q <= in_beat;
        end
    end

    assign s.tready = !spare_v;
    assign m.tvalid = main_v;
    assign m.tdata  = main_q.data;
    assign m.tkeep  = main_q.keep;
    assign m.tlast  = main_q.last;
    assign m.tuser  = main_q.user;

    a_no_drop: assert property (@(posedge clk) disable iff (rst)
        m.tvalid && !m.tready |=> m.tvalid);

endmodule

`default_nettype wire

/* wg_disassembler.sv */
// --------------------
// WireGuard disassembler
// Classifies frames on entry, strips and realigns on exit
// --------------------
`default_nettype none

module wg_disassembler (
    input  logic clk,
    input  logic rst,
    pkt_if.snk   inp,
    pkt_if.src   outp,
    wg_ctl_if.dp ctl
);
    import dpe_pkg::*;
    import wg_proto_pkg::*;

    typedef enum logic [2:0] {IN_B0, IN_B1, IN_B2, IN_B3, IN_BODY} in_state_t;
    typedef enum logic [1:0] {OUT_WAIT, OUT_DROP, OUT_PAY, OUT_BYP} out_state_t;

    in_state_t  in_st;
    out_state_t out_st;
    logic       hdr_ok;
    logic       dec_vld;
    logic       dec_wg;
    logic [1:0] drop_cnt;
    rcv_idx_t   rcv;
    wg_ctr_t    ctr;
    enp_t       enp;
    logic       in_acc;
    logic       pipe_acc;
    logic       wg_match;
    logic       take_dec;

    pkt_if #(.USER_W($bits(in_user_t)))  pipe_out ();
    pkt_if #(.USER_W($bits(out_user_t))) skid_in ();

    pkt_pipe #(.USER_W($bits(in_user_t))) u_pipe (.clk, .rst, .s(inp), .m(pipe_out));
    pkt_skid #(.USER_W($bits(out_user_t))) u_skid (.clk, .rst, .s(skid_in), .m(outp));

    assign in_acc   = inp.tvalid && inp.tready;
    assign pipe_acc = pipe_out.tvalid && pipe_out.tready;
    assign take_dec = (out_st == OUT_WAIT) && dec_vld && pipe_acc;
    assign wg_match = ctl.decap_en && hdr_ok && (inp.tdata[WG_TYPE_LSB +: 8] == WG_MSG_DATA);

    // --------------------
    // Entry side classifier
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            in_st        <= IN_B0;
            hdr_ok       <= 1'b0;
            dec_vld      <= 1'b0;
            dec_wg       <= 1'b0;
            rcv          <= '0;
            ctr          <= '0;
            ctl.wg_done  <= 1'b0;
            ctl.byp_done <= 1'b0;
        end else begin
            ctl.wg_done  <= 1'b0;
            ctl.byp_done <= 1'b0;
            if (take_dec) begin
                dec_vld <= 1'b0;
            end
            // Last decapsulated beat leaving, so the next frame starts clean
            if (pipe_acc && out_st == OUT_PAY && pipe_out.tlast) begin
                rcv <= '0;
                ctr <= '0;
            end
            if (in_acc) begin
                case (in_st)
                    IN_B0: begin
                        hdr_ok <= (inp.tdata[ETH_TYPE_LSB +: 16] == ETHERTYPE_IP_LANES) &&
                                  (inp.tdata[IP_VER_LSB +: 4] == IPV4_VERSION);
                        in_st  <= IN_B1;
                    end
                    IN_B1: begin
                        hdr_ok <= hdr_ok && (inp.tdata[IP_PROTO_LSB +: 8] == IPPROTO_UDP);
                        in_st  <= IN_B2;
                    end
                    IN_B2: begin
                        dec_vld      <= 1'b1;
                        dec_wg       <= wg_match;
                        ctl.wg_done  <= wg_match;
                        ctl.byp_done <= !wg_match;
                        if (wg_match) begin
                            rcv[15:0] <= inp.tdata[WG_RCV_LO_LSB +: 16];
                        end
                        in_st <= wg_match ? IN_B3 : IN_BODY;
                    end
                    IN_B3: begin
                        rcv[31:16] <= inp.tdata[WG_RCV_HI_LSB +: 16];
                        ctr        <= inp.tdata[WG_CTR_LSB +: 64];
                        in_st      <= inp.tlast ? IN_B0 : IN_BODY;
                    end
                    default: begin
                        if (inp.tlast) begin
                            in_st <= IN_B0;
                        end
                    end
                endcase
            end
        end
    end

    // --------------------
    // Exit side realigner
    // --------------------
    always_comb begin
        skid_in.tvalid = 1'b0;
        skid_in.tdata  = pipe_out.tdata;
        skid_in.tkeep  = pipe_out.tkeep;
        skid_in.tlast  = pipe_out.tlast;
        skid_in.tuser  = '0;
        skid_in.tuser[OUSER_IN_LSB +: $bits(in_user_t)] = pipe_out.tuser;
        pipe_out.tready = 1'b0;
        case (out_st)
            OUT_WAIT: begin
                // Hold beat 0 until its frame has been classified
                if (dec_vld && dec_wg) begin
                    pipe_out.tready = 1'b1;
                end else if (dec_vld) begin
                    skid_in.tvalid  = pipe_out.tvalid;
                    pipe_out.tready = skid_in.tready;
                end
            end
            OUT_DROP: pipe_out.tready = 1'b1;
            OUT_PAY: begin
                skid_in.tvalid = pipe_out.tvalid;
                skid_in.tdata  = {pipe_out.tdata[PAYLOAD_LSB-1:0], enp};
                skid_in.tkeep  = '1;
                skid_in.tuser[OUSER_RCV_LSB +: $bits(rcv_idx_t)] = rcv;
                skid_in.tuser[OUSER_CTR_LSB +: $bits(wg_ctr_t)]  = ctr;
                skid_in.tuser[OUSER_DECAP_BIT] = 1'b1;
                pipe_out.tready = skid_in.tready;
            end
            default: begin
                skid_in.tvalid  = pipe_out.tvalid;
                pipe_out.tready = skid_in.tready;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_st   <= OUT_WAIT;
            drop_cnt <= '0;
        end else if (pipe_acc) begin
            case (out_st)
                OUT_WAIT: begin
                    drop_cnt <= 2'd1;
                    out_st   <= dec_wg ? OUT_DROP : OUT_BYP;
                end
                OUT_DROP: begin
                    drop_cnt <= drop_cnt + 2'd1;
                    if (drop_cnt == 2'(HDR_BEATS)) begin
                        out_st <= OUT_PAY;
                    end
                end
                default: begin
                    if (pipe_out.tlast) begin
                        out_st <= OUT_WAIT;
                    end
                end
            endcase
        end
    end

    // Top 6 bytes of the last header beat, then of each payload beat
    always_ff @(posedge clk) begin
        if (pipe_acc && (out_st == OUT_PAY ||
                         (out_st == OUT_DROP && drop_cnt == 2'(HDR_BEATS)))) begin
            enp <= pipe_out.tdata[127:PAYLOAD_LSB];
        end
    end

    assign ctl.idle = (in_st == IN_B0) && (out_st == OUT_WAIT) && !outp.tvalid;

    a_dec_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ctl.wg_done, ctl.byp_done}));

endmodule

`default_nettype wire

/* wg_regs.sv */
// --------------------
// Control and status registers
// Decap enable and saturating frame counters
// --------------------
`default_nettype none

module wg_regs #(
    parameter int CNT_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  dpe_pkg::reg_addr_t addr,
    input  dpe_pkg::reg_data_t wdata,
    output dpe_pkg::reg_data_t rdata,
    wg_ctl_if.regs            ctl
);
    import dpe_pkg::*;

    logic [CNT_W-1:0] wg_cnt;
    logic [CNT_W-1:0] byp_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctl.decap_en <= 1'b1;
            wg_cnt       <= '0;
            byp_cnt      <= '0;
        end else begin
            if (we && addr == REG_CTRL) begin
                ctl.decap_en <= wdata[CTRL_DECAP_EN_BIT];
            end
            // A write to a counter clears it, even against a pulse
            if (we && addr == REG_WG_CNT) begin
                wg_cnt <= '0;
            end else if (ctl.wg_done && wg_cnt != '1) begin
                wg_cnt <= wg_cnt + 1'b1;
            end
            if (we && addr == REG_BYP_CNT) begin
                byp_cnt <= '0;
            end else if (ctl.byp_done && byp_cnt != '1) begin
                byp_cnt <= byp_cnt + 1'b1;
            end
        end
    end

    // Registered read
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else begin
            case (addr)
                REG_CTRL:    rdata <= reg_data_t'(ctl.decap_en);
                REG_WG_CNT:  rdata <= reg_data_t'(wg_cnt);
                REG_BYP_CNT: rdata <= reg_data_t'(byp_cnt);
                default:     rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* wg_rx_top.sv */
// --------------------
// WireGuard receive top level
// Disassembler datapath plus its register block
// --------------------
`default_nettype none

module wg_rx_top #(
    parameter int CNT_W = 32
) (
    input  logic               clk,
    input  logic               rst,
    // Ingress stream
    input  logic               in_tvalid,
    output logic               in_tready,
    input  dpe_pkg::tdata_t    in_tdata,
    input  dpe_pkg::tkeep_t    in_tkeep,
    input  logic               in_tlast,
    input  dpe_pkg::in_user_t  in_tuser,
    // Egress stream
    output logic               out_tvalid,
    input  logic               out_tready,
    output dpe_pkg::tdata_t    out_tdata,
    output dpe_pkg::tkeep_t    out_tkeep,
    output logic               out_tlast,
    output dpe_pkg::out_user_t out_tuser,
    // Register port
    input  logic               reg_we,
    input  dpe_pkg::reg_addr_t reg_addr,
    input  dpe_pkg::reg_data_t reg_wdata,
    output dpe_pkg::reg_data_t reg_rdata,
    output logic               is_idle
);
    import dpe_pkg::*;

    pkt_if #(.USER_W($bits(in_user_t)))  in_if ();
    pkt_if #(.USER_W($bits(out_user_t))) out_if ();
    wg_ctl_if                             ctl_if ();

    assign in_if.tvalid  = in_tvalid;
    assign in_if.tdata   = in_tdata;
    assign in_if.tkeep   = in_tkeep;
    assign in_if.tlast   = in_tlast;
    assign in_if.tuser   = in_tuser;
    assign in_tready     = in_if.tready;

    assign out_tvalid    = out_if.tvalid;
    assign out_tdata     = out_if.tdata;
    assign out_tkeep     = out_if.tkeep;
    assign out_tlast     = out_if.tlast;
    assign out_tuser     = out_if.tuser;
    assign out_if.tready = out_tready;

    assign is_idle = ctl_if.idle;

    wg_disassembler u_dis (.clk, .rst, .inp(in_if), .outp(out_if), .ctl(ctl_if));

    wg_regs #(.CNT_W(CNT_W)) u_regs (
        .clk, .rst, .we(reg_we), .addr(reg_addr), .wdata(reg_wdata),
        .rdata(reg_rdata), .ctl(ctl_if)
    );

endmodule

`default_nettype wire

/* tb_wg_rx.sv */
// --------------------
// Testbench for the WireGuard receive top level
// Directed frames against a realignment reference model
// --------------------
`default_nettype none

module tb_wg_rx;
    timeunit 1ns;
    timeprecision 100ps;

    import dpe_pkg::*;
    import wg_proto_pkg::*;

    localparam int TIMEOUT = 500;

    logic      clk;
    logic      rst;
    logic      in_tvalid;
    logic      in_tready;
    tdata_t    in_tdata;
    tkeep_t    in_tkeep;
    logic      in_tlast;
    in_user_t  in_tuser;
    logic      out_tvalid;
    logic      out_tready;
    tdata_t    out_tdata;
    tkeep_t    out_tkeep;
    logic      out_tlast;
    out_user_t out_tuser;
    logic      reg_we;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    reg_data_t reg_rdata;
    logic      is_idle;

    // Beats waiting to be driven
    tdata_t    in_data [$];
    tkeep_t    in_keep [$];
    logic      in_last [$];
    in_user_t  in_user [$];

    // Expected output beats from the model
    tdata_t    exp_data [$];
    tkeep_t    exp_keep [$];
    logic      exp_last [$];
    out_user_t exp_user [$];

    logic [31:0] lfsr;
    logic        decap_en_exp;
    int          exp_wg;
    int          exp_byp;

    wg_rx_top #(.CNT_W(32)) uut (
        .clk, .rst,
        .in_tvalid, .in_tready, .in_tdata, .in_tkeep, .in_tlast, .in_tuser,
        .out_tvalid, .out_tready, .out_tdata, .out_tkeep, .out_tlast, .out_tuser,
        .reg_we, .reg_addr, .reg_wdata, .reg_rdata, .is_idle
    );

    always #50 clk = ~clk;

    // --------------------
    // Random source
    // --------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
        return v;
    endfunction

    // --------------------
    // Failure reporting and compares
    // --------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(input tdata_t got, input tdata_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail out_tdata: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_user(input out_user_t got, input out_user_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail out_tuser: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_keep(input tkeep_t got, input tkeep_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail out_tkeep: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail out_tlast: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    // --------------------
    // Register port
    // --------------------
    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #5;
        reg_we = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t val);
        reg_addr = addr;
        @(posedge clk);
        @(negedge clk);
        val = reg_rdata;
        @(posedge clk);
        #5;
    endtask

    task automatic check_counters();
        reg_data_t v;
        reg_read(REG_WG_CNT, v);
        check_reg("REG_WG_CNT", v, reg_data_t'(exp_wg));
        reg_read(REG_BYP_CNT, v);
        check_reg("REG_BYP_CNT", v, reg_data_t'(exp_byp));
    endtask

    // --------------------
    // Frame builder and reference model
    // --------------------
    // Kind 0 non-IP, 1 IPv4 TCP, 2 UDP non-WireGuard, 3 WireGuard data
    task automatic add_frame(input int kind, input int nbeats);
        tdata_t    fb [8];
        in_user_t  fu [8];
        tkeep_t    keep;
        out_user_t ou;
        logic      decap;
        for (int i = 0; i < nbeats; i++) begin
            for (int b = 0; b < 16; b++) begin
                fb[i][b*8 +: 8] = 8'(rand_bits(8));
            end
            fu[i] = in_user_t'(rand_bits(5));
        end
        fb[0][ETH_TYPE_LSB +: 16] = (kind == 0) ? 16'hdd86 : ETHERTYPE_IP_LANES;
        fb[0][IP_VER_LSB +: 4]    = IPV4_VERSION;
        fb[1][IP_PROTO_LSB +: 8]  = (kind == 1) ? 8'h06 : IPPROTO_UDP;
        fb[2][WG_TYPE_LSB +: 8]   = (kind == 2) ? 8'h01 : WG_MSG_DATA;
        decap = (kind == 3) && decap_en_exp;
        if (decap) begin
            exp_wg++;
        end else begin
            exp_byp++;
        end
        for (int i = 0; i < nbeats; i++) begin
            keep = (i == nbeats - 1) ? 16'h3fff : '1;
            in_data.push_back(fb[i]);
            in_keep.push_back(keep);
            in_last.push_back(i == nbeats - 1);
            in_user.push_back(fu[i]);
            if (!decap) begin
                ou = '0;
                ou[4:0] = fu[i];
                exp_data.push_back(fb[i]);
                exp_keep.push_back(keep);
                exp_last.push_back(i == nbeats - 1);
                exp_user.push_back(ou);
            end
        end
        // 58 header bytes dropped, payload pulled down to lane 0
        if (decap) begin
            for (int k = 4; k < nbeats; k++) begin
                ou = '0;
                ou[127:96] = {fb[3][15:0], fb[2][127:112]};
                ou[95:32]  = fb[3][79:16];
                ou[5]      = 1'b1;
                ou[4:0]    = fu[k];
                exp_data.push_back({fb[k][79:0], fb[k-1][127:80]});
                exp_keep.push_back('1);
                exp_last.push_back(k == nbeats - 1);
                exp_user.push_back(ou);
            end
        end
    endtask

    // --------------------
    // Traffic
    // --------------------
    task automatic drive_input(input bit gaps);
        int wait_cycles;
        while (in_data.size() > 0) begin
            if (gaps && rand_bits(2) == 32'd3) begin
                in_tvalid = 1'b0;
                @(posedge clk);
                #5;
            end else begin
                in_tvalid   = 1'b1;
                in_tdata    = in_data[0];
                in_tkeep    = in_keep[0];
                in_tlast    = in_last[0];
                in_tuser    = in_user[0];
                wait_cycles = 0;
                @(negedge clk);
                while (!in_tready) begin
                    wait_cycles++;
                    if (wait_cycles > TIMEOUT) begin
                        stop_run("timeout: in_tready stayed low");
                    end
                    @(negedge clk);
                end
                @(posedge clk);
                #5;
                void'(in_data.pop_front());
                void'(in_keep.pop_front());
                void'(in_last.pop_front());
                void'(in_user.pop_front());
            end
        end
        in_tvalid = 1'b0;
    endtask

    task automatic collect_output(input bit gaps);
        int idle_cycles;
        idle_cycles = 0;
        while (exp_data.size() > 0) begin
            out_tready = gaps ? (rand_bits(2) != 32'd3) : 1'b1;
            @(negedge clk);
            if (out_tvalid && out_tready) begin
                check_data(out_tdata, exp_data[0]);
                check_keep(out_tkeep, exp_keep[0]);
                check_last(out_tlast, exp_last[0]);
                check_user(out_tuser, exp_user[0]);
                void'(exp_data.pop_front());
                void'(exp_keep.pop_front());
                void'(exp_last.pop_front());
                void'(exp_user.pop_front());
                idle_cycles = 0;
            end else begin
                idle_cycles++;
                if (idle_cycles > TIMEOUT) begin
                    stop_run("timeout: expected output beat never arrived");
                end
            end
            @(posedge clk);
            #5;
        end
        out_tready = 1'b1;
    endtask

    // All expected beats are taken, so any further beat is an extra one
    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (!is_idle) begin
            if (out_tvalid) begin
                stop_run("unexpected output beat after the last expected one");
            end
            n++;
            if (n > TIMEOUT) begin
                stop_run("timeout: is_idle did not return high");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #5;
    endtask

    task automatic run_traffic(input bit gaps);
        fork
            drive_input(gaps);
            collect_output(gaps);
        join
        wait_idle();
        check_counters();
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset();
        reg_data_t v;
        reg_read(REG_CTRL, v);
        check_reg("REG_CTRL", v, 32'd1);
        check_counters();
        @(negedge clk);
        check_flag("is_idle", is_idle, 1'b1);
        check_flag("out_tvalid", out_tvalid, 1'b0);
        @(posedge clk);
        #5;
        reg_write(REG_CTRL, 32'd0);
        reg_read(REG_CTRL, v);
        check_reg("REG_CTRL", v, 32'd0);
        reg_write(REG_CTRL, 32'd1);
        reg_read(REG_CTRL, v);
        check_reg("REG_CTRL", v, 32'd1);
    endtask

    task automatic test_bypass();
        add_frame(0, 4);
        add_frame(1, 5);
        add_frame(2, 6);
        run_traffic(1'b0);
    endtask

    task automatic test_decap(input bit gaps);
        add_frame(3, 7);
        run_traffic(gaps);
    endtask

    // Sideband of the bypass frame must not carry the previous index
    task automatic test_decap_then_bypass(input bit gaps);
        add_frame(3, 6);
        add_frame(2, 5);
        run_traffic(gaps);
    endtask

    task automatic test_decap_disabled();
        reg_write(REG_CTRL, 32'd0);
        decap_en_exp = 1'b0;
        add_frame(3, 6);
        run_traffic(1'b0);
        reg_write(REG_WG_CNT, 32'd0);
        exp_wg = 0;
        check_counters();
        reg_write(REG_CTRL, 32'd1);
        decap_en_exp = 1'b1;
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        in_tvalid    = 1'b0;
        in_tdata     = '0;
        in_tkeep     = '0;
        in_tlast     = 1'b0;
        in_tuser     = '0;
        out_tready   = 1'b1;
        reg_we       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        lfsr         = 32'ha001;
        decap_en_exp = 1'b1;
        exp_wg       = 0;
        exp_byp      = 0;
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;

        test_reset();
        test_bypass();
        test_decap(1'b0);
        test_decap_then_bypass(1'b0);
        test_decap(1'b1);
        test_decap_then_bypass(1'b1);
        test_decap_disabled();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
dpe_pkg.sv
wg_proto_pkg.sv
pkt_if.sv
pkt_pipe.sv
pkt_skid.sv
wg_disassembler.sv
wg_regs.sv
wg_rx_top.sv
tb_wg_rx.sv

/* Bender.yml */
package:
  name: wg_rx

sources:
  - dpe_pkg.sv
  - wg_proto_pkg.sv
  - pkt_if.sv
  - pkt_pipe.sv
  - pkt_skid.sv
  - wg_disassembler.sv
  - wg_regs.sv
  - wg_rx_top.sv
  - target: test
    files:
      - tb_wg_rx.sv
